//--- hdl/dot_config.svh
// Dot product sizing
`ifndef DOT_CONFIG_SVH
`define DOT_CONFIG_SVH

// ----------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------
`define DOT_DATA_WIDTH  8    // One signed vector element
`define DOT_ACCUM_WIDTH 32   // Accumulator and result, wraps on overflow

// ----------------------------------------------------------
// Buffer geometry
// ----------------------------------------------------------
`define DOT_MAX_LEN     16   // Element pairs held on chip
`define DOT_ADDR_WIDTH  4    // Index into the buffer
// One bit wider than the address so a full-length vector fits
`define DOT_LEN_WIDTH   5

`endif

//--- hdl/dot_pkg.sv
// Dot product types
`default_nettype none
`include "dot_config.svh"

package dot_pkg;

    // ----------------------------------------------------------
    // Scalar types
    // ----------------------------------------------------------
    typedef logic signed [`DOT_DATA_WIDTH-1:0]  elem_t;  // Vector element
    typedef logic signed [`DOT_ACCUM_WIDTH-1:0] acc_t;   // Running sum and result
    typedef logic        [`DOT_LEN_WIDTH-1:0]   len_t;   // Length or element count
    typedef logic        [`DOT_ADDR_WIDTH-1:0]  addr_t;  // Buffer index

    // ----------------------------------------------------------
    // Element pair
    // ----------------------------------------------------------
    // One buffer entry, also the MAC operand pair
    typedef struct packed {
        elem_t a;  // Element of vector A
        elem_t b;  // Element of vector B
    } elem_pair_t;

endpackage

`default_nettype wire

//--- hdl/vector_buffer.sv
// Vector element buffer
`timescale 1ns/1ps
`default_nettype none
`include "dot_config.svh"

module vector_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,    // Host write strobe
    input  dot_pkg::addr_t      wr_addr,
    input  dot_pkg::elem_pair_t wr_pair,
    input  logic                start,    // Rewind to entry 0
    input  logic                rd_req,   // Fetch next pair
    output dot_pkg::elem_pair_t rd_pair   // Valid the cycle after rd_req
);
    import dot_pkg::*;

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    elem_pair_t mem [`DOT_MAX_LEN];  // Register array, contents unknown until written
    addr_t      rd_ptr;              // Next entry to fetch

    // Host side, any address at any time
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_pair;  // Visible to a read one cycle later
        end
    end

    // ----------------------------------------------------------
    // Read pointer
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (start) begin
            rd_ptr <= '0;             // New run reads from the top
        end else if (rd_req) begin
            rd_ptr <= rd_ptr + 1'b1;  // Wraps at DOT_MAX_LEN
        end
    end

    // Fetch stage
    // Registered read, payload only so no reset
    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_pair <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/mac_unit.sv
// Two-stage signed MAC
`timescale 1ns/1ps
`default_nettype none
`include "dot_config.svh"

module mac_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,         // One-cycle operand strobe
    input  dot_pkg::elem_pair_t op_pair,
    input  dot_pkg::acc_t       accum_in,
    output dot_pkg::acc_t       accum_out   // Holds until the next en
);
    import dot_pkg::*;

    logic signed [2*`DOT_DATA_WIDTH-1:0] prod_full;  // Exact product, no overflow
    acc_t prod_q;    // Stage one product, sign extended
    acc_t addend_q;  // Stage one copy of accum_in
    logic s1_valid;  // Stage one holds fresh operands

    assign prod_full = op_pair.a * op_pair.b;  // Signed by member type

    // ----------------------------------------------------------
    // Stage one
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (en) begin
            prod_q   <= acc_t'(prod_full);  // Extend to accumulator width
            addend_q <= accum_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            accum_out <= '0;
        end else begin
            s1_valid <= en;                        // Stage two fires once per en
            if (s1_valid) begin
                accum_out <= prod_q + addend_q;    // Stage two, wraps in 32 bits
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/dot_product_unit.sv
// Dot product sequencer
`timescale 1ns/1ps
`default_nettype none
`include "dot_config.svh"

module dot_product_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,                  // Honored in IDLE only
    input  dot_pkg::len_t  vector_length,          // Sampled with start
    output logic           mac_en,
    output dot_pkg::acc_t  accum_in,               // Running sum to the MAC
    input  dot_pkg::acc_t  accum_out,              // MAC result
    output logic           request_next_elements,  // Buffer fetch strobe
    output dot_pkg::acc_t  result_out,
    output logic           result_valid,           // One cycle
    output logic           busy
);
    import dot_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_INIT,       // Clear sum and counter
        S_REQUEST,    // Fetch a pair or finish
        S_START_MAC,  // Operands on rd_pair
        S_WAIT_S1,    // MAC stage one
        S_WAIT_S2,    // MAC stage two
        S_CAPTURE,    // Take accum_out
        S_OUTPUT      // Present result
    } state_t;

    state_t state;
    state_t state_nxt;
    acc_t   sum_q;     // Running sum
    len_t   count_q;   // Pairs done so far
    len_t   length_q;  // Latched vector length
    logic   more;      // Pairs still to go

    assign more = (count_q < length_q);

    // ----------------------------------------------------------
    // State register
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        state_nxt = state;  // Hold by default
        case (state)
            S_IDLE: begin
                if (start) begin
                    state_nxt = S_INIT;
                end
            end
            S_INIT:      state_nxt = S_REQUEST;
            S_REQUEST:   state_nxt = more ? S_START_MAC : S_OUTPUT;
            S_START_MAC: state_nxt = S_WAIT_S1;
            S_WAIT_S1:   state_nxt = S_WAIT_S2;
            S_WAIT_S2:   state_nxt = S_CAPTURE;  // accum_out settles at the end of this
            S_CAPTURE:   state_nxt = S_REQUEST;
            S_OUTPUT:    state_nxt = S_IDLE;
            default:     state_nxt = S_IDLE;
        endcase
    end

    // Strobes and levels straight from state
    assign request_next_elements = (state == S_REQUEST) && more;
    assign mac_en                = (state == S_START_MAC);
    assign result_valid          = (state == S_OUTPUT);
    assign busy                  = (state != S_IDLE) && (state != S_OUTPUT);
    assign accum_in              = sum_q;

    // ----------------------------------------------------------
    // Sum, counter and result
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_q      <= {`DOT_ACCUM_WIDTH{1'b0}};
            count_q    <= '0;
            length_q   <= '0;
            result_out <= {`DOT_ACCUM_WIDTH{1'b0}};
        end else begin
            // Entry to INIT, i.e. start seen in IDLE
            if (state == S_IDLE && start) begin
                sum_q    <= {`DOT_ACCUM_WIDTH{1'b0}};
                count_q  <= '0;
                length_q <= vector_length;
            end
            if (state == S_CAPTURE) begin
                sum_q   <= accum_out;       // Partial sum through this pair
                count_q <= count_q + 1'b1;
            end
            // Load on entry so the value lines up with result_valid
            if (state == S_REQUEST && !more) begin
                result_out <= sum_q;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/dot_product_top.sv
// Dot product top level
`timescale 1ns/1ps
`default_nettype none
`include "dot_config.svh"

module dot_product_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,          // Buffer write port
    input  dot_pkg::addr_t      wr_addr,
    input  dot_pkg::elem_pair_t wr_pair,
    input  logic                start,          // Run pulse
    input  dot_pkg::len_t       vector_length,
    output dot_pkg::acc_t       result_out,
    output logic                result_valid,
    output logic                busy
);
    import dot_pkg::*;

    elem_pair_t rd_pair;   // Fetched operands
    acc_t       accum_in;  // Sequencer sum to MAC
    acc_t       accum_out; // MAC back to sequencer
    logic       rd_req;    // Fetch strobe
    logic       mac_en;
    logic       rewind;    // Start the sequencer will accept

    assign rewind = start & ~busy;  // Keeps the pointer during a run

    // ----------------------------------------------------------
    // Fetch, sequence, MAC
    // ----------------------------------------------------------
    vector_buffer u_buffer (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_pair(wr_pair),
        .start(rewind), .rd_req(rd_req), .rd_pair(rd_pair)
    );

    dot_product_unit u_seq (
        .clk(clk), .rst_n(rst_n),
        .start(start), .vector_length(vector_length),
        .mac_en(mac_en), .accum_in(accum_in), .accum_out(accum_out),
        .request_next_elements(rd_req),
        .result_out(result_out), .result_valid(result_valid), .busy(busy)
    );

    mac_unit u_mac (
        .clk(clk), .rst_n(rst_n),
        .en(mac_en), .op_pair(rd_pair),
        .accum_in(accum_in), .accum_out(accum_out)
    );

endmodule

`default_nettype wire

//--- sim/tb_dot_product.sv
// Dot product testbench
`timescale 1ns/1ps
`default_nettype none
`include "dot_config.svh"

module tb_dot_product;
    import dot_pkg::*;

    // ----------------------------------------------------------
    // Timing and run budget
    // ----------------------------------------------------------
    localparam int CLK_PERIOD    = 40;
    localparam int NUM_RUNS      = 14;                      // At least the run_dot calls below
    localparam int RUN_CYCLES    = 5 * `DOT_MAX_LEN + 10;  // Longest run plus idle tail
    localparam int WRITE_CYCLES  = 8 * `DOT_MAX_LEN;       // Buffer loads, two cycles each
    localparam int MARGIN_CYCLES = 200;
    localparam longint WATCHDOG_NS =
        longint'(NUM_RUNS * RUN_CYCLES + WRITE_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    logic       clk;
    logic       rst_n;
    logic       wr_en;
    addr_t      wr_addr;
    elem_pair_t wr_pair;
    logic       start;
    len_t       vector_length;
    acc_t       result_out;
    logic       result_valid;
    logic       busy;

    elem_pair_t  shadow [`DOT_MAX_LEN];  // Copy of every pair written to the DUT
    logic [31:0] lfsr_state;

    dot_product_top u_dot_product_top (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_pair(wr_pair),
        .start(start), .vector_length(vector_length),
        .result_out(result_out), .result_valid(result_valid), .busy(busy)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------------------------
    // Failure handling and compares
    // ----------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0d ns: %s, got %0d expected %0d",
                                $time, what, $signed(actual), $signed(expected)));
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);  // Galois form, right shift
    endfunction

    // One LFSR step per bit handed out
    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Sum of a*b over the first len entries, wrapping like a 32-bit accumulator
    function automatic acc_t expected_dot(input int len);
        int sum;
        int i;
        sum = 0;
        for (i = 0; i < len; i++) begin
            sum += int'(shadow[i].a) * int'(shadow[i].b);
        end
        return acc_t'(sum);
    endfunction

    task automatic write_pair(input int addr, input int a, input int b);
        @(negedge clk);
        wr_en     = 1'b1;
        wr_addr   = addr_t'(addr);
        wr_pair.a = elem_t'(a);
        wr_pair.b = elem_t'(b);
        shadow[addr] = wr_pair;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // Pulse start, wait for result_valid, check latency, value and single pulse.
    // poke_at >= 0 pulses start again that many cycles after edge 0
    task automatic run_dot(input int len, input acc_t expected, input int poke_at,
                           input string name);
        int cycles;
        int limit;
        limit = 5 * len + 2;                  // Edge of result_valid after edge 0
        @(negedge clk);
        start         = 1'b1;
        vector_length = len_t'(len);
        @(negedge clk);                       // Edge 0 has sampled start
        start  = 1'b0;
        cycles = 0;
        while (result_valid !== 1'b1) begin
            if (cycles > limit) begin
                abort_run($sformatf("%s: result_valid did not arrive within %0d cycles",
                                    name, limit));
            end else begin
                check_equal(busy, 1, $sformatf("%s, busy during run", name));
                if (cycles == poke_at) begin
                    start         = 1'b1;     // Should be ignored
                    vector_length = len_t'(len / 2);
                end else begin
                    start = 1'b0;
                end
                @(negedge clk);
                cycles++;
            end
        end
        start = 1'b0;
        check_equal(cycles, limit, $sformatf("%s, result_valid latency", name));
        check_equal(result_out, expected, $sformatf("%s, result", name));
        check_equal(busy, 0, $sformatf("%s, busy with result", name));
        repeat (4) begin
            @(negedge clk);
            check_equal(result_valid, 0, $sformatf("%s, one result pulse", name));
            check_equal(busy, 0, $sformatf("%s, idle after run", name));
        end
    endtask

    // ----------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------
    task automatic test_reset_state();
        @(negedge clk);
        check_equal(busy, 0, "busy after reset");
        check_equal(result_valid, 0, "result_valid after reset");
        check_equal(result_out, 0, "result_out after reset");
    endtask

    task automatic test_known_vector();
        write_pair(0, 1, 2);
        write_pair(1, 3, 4);
        write_pair(2, -5, 6);
        write_pair(3, 7, -8);
        run_dot(4, -72, -1, "known vector");  // 2 + 12 - 30 - 56
    endtask

    task automatic test_zero_length();
        run_dot(0, 0, -1, "zero length");
    endtask

    task automatic test_full_and_random();
        logic [31:0] a_bits;
        logic [31:0] b_bits;
        logic [31:0] len_bits;
        int i;
        int len;
        for (i = 0; i < `DOT_MAX_LEN; i++) begin
            take_bits(8, a_bits);
            take_bits(8, b_bits);
            write_pair(i, $signed(a_bits[7:0]), $signed(b_bits[7:0]));
        end
        write_pair(3, -128, -128);   // Largest positive product
        write_pair(9, 127, -128);    // Largest negative product
        run_dot(`DOT_MAX_LEN, expected_dot(`DOT_MAX_LEN), -1, "full length");
        repeat (6) begin
            take_bits(5, len_bits);
            len = int'(len_bits[4:0]) % (`DOT_MAX_LEN + 1);
            run_dot(len, expected_dot(len), -1, $sformatf("random length %0d", len));
        end
    endtask

    // Same buffer, no rewrite, so the pointer must start over
    task automatic test_rewind();
        run_dot(`DOT_MAX_LEN, expected_dot(`DOT_MAX_LEN), -1, "rewind full");
        run_dot(5, expected_dot(5), -1, "rewind shorter");
    endtask

    task automatic test_start_while_busy();
        run_dot(10, expected_dot(10), 12, "start while busy");
    endtask

    // ----------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------
    initial begin
        #(WATCHDOG_NS);
        abort_run("Watchdog expired before the tests completed");
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        rst_n         = 1'b0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_pair       = '0;
        start         = 1'b0;
        vector_length = '0;
        lfsr_state    = 32'hb14b;
        repeat (3) @(negedge clk);  // Three rising edges in reset
        rst_n = 1'b1;

        test_reset_state();
        test_known_vector();
        test_zero_length();
        test_full_and_random();
        test_rewind();
        test_start_while_busy();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/dot_pkg.sv
hdl/vector_buffer.sv
hdl/mac_unit.sv
hdl/dot_product_unit.sv
hdl/dot_product_top.sv
sim/tb_dot_product.sv

//--- Makefile
# Verilator build and run for the dot product testbench

VERILATOR   ?= verilator
TOP         ?= tb_dot_product
FILELIST    ?= list.f
BUILD_DIR   ?= obj_dir
JOBS        ?= 0
VFLAGS      ?= --binary --timing -Wno-fatal -j $(JOBS)
PASS_STRING ?= Simulation finished: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS PASS_STRING"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_STRING)"

clean:
	rm -rf $(BUILD_DIR)
